//--- design/fetch_pkg.sv
package fetch_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] addr_t;
  typedef logic [XLEN-1:0] inst_t;

  localparam addr_t PC_RESET = 32'h8000_0000;

  // Direct-mapped L1I of 4 sets with two-word lines.
  localparam int L1I_SETS = 4;
  localparam int L1I_WORDS = 2;
  localparam int INDEX_W = 2;
  localparam int OFFSET_W = 1;
  localparam int TAG_W = XLEN - INDEX_W - OFFSET_W - 2;

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [OFFSET_W-1:0] offset_t;

  localparam logic [6:0] OP_JAL = 7'b1101111;
  localparam logic [6:0] OP_JALR = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_MISC_MEM = 7'b0001111;

  localparam inst_t INST_FENCE_I = 32'h0000_100f;

  typedef enum logic [1:0] {
    KIND_SEQ,
    KIND_CTRL,
    KIND_FENCE_I
  } inst_kind_e;

  typedef enum logic [1:0] {
    L1I_IDLE,
    L1I_REQ,
    L1I_BEAT0,
    L1I_BEAT1
  } l1i_state_e;

  typedef struct packed {
    addr_t pc;
  } fetch_req_t;

  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fetch_rsp_t;

  typedef struct packed {
    addr_t      pc;
    inst_t      inst;
    inst_kind_e kind;
  } fetch_out_t;

  typedef struct packed {
    addr_t addr;  // Line aligned.
  } mem_req_t;

  typedef struct packed {
    inst_t data;
    logic  last;
  } mem_rsp_t;

endpackage

//--- design/pc_gen.sv
`timescale 1ns/1ns

module pc_gen (
  input  logic                  clk,
  input  logic                  rst,
  output fetch_pkg::fetch_req_t req_o,
  output logic                  req_valid_o,
  input  logic                  req_ready_i,
  input  logic                  halt_i,
  input  logic                  redirect_valid_i,
  input  fetch_pkg::addr_t      redirect_pc_i
);

  fetch_pkg::addr_t pc_q;
  logic             issue_q;  // Fetch has started.
  logic             accept;

  assign req_o.pc = pc_q;

  // A halt withdraws the wrong-path request, the redirect replaces it.
  assign req_valid_o = issue_q && !halt_i;
  assign accept = req_valid_o && req_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      issue_q <= 1'b0;
    end else begin
      issue_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= fetch_pkg::PC_RESET;
    end else if (redirect_valid_i) begin
      pc_q <= redirect_pc_i;  // Restart at the target.
    end else if (accept) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  // The execute side only redirects a front end that has stopped.
  a_redirect_halted: assert property (
    @(posedge clk) disable iff (rst)
    redirect_valid_i |-> halt_i
  ) else $error("pc_gen: redirect while not halted");

endmodule

//--- design/l1i_cache.sv
`timescale 1ns/1ns

module l1i_cache (
  input  logic                  clk,
  input  logic                  rst,
  input  fetch_pkg::fetch_req_t req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  output fetch_pkg::fetch_rsp_t rsp_o,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  input  logic                  flush_i,
  output fetch_pkg::mem_req_t   mem_req_o,
  output logic                  mem_req_valid_o,
  input  logic                  mem_req_ready_i,
  input  fetch_pkg::mem_rsp_t   mem_rsp_i,
  input  logic                  mem_rsp_valid_i
);

  function automatic fetch_pkg::tag_t pc_tag(input fetch_pkg::addr_t pc);
    return pc[fetch_pkg::XLEN-1 -: fetch_pkg::TAG_W];
  endfunction

  function automatic fetch_pkg::index_t pc_index(input fetch_pkg::addr_t pc);
    return pc[fetch_pkg::OFFSET_W+2 +: fetch_pkg::INDEX_W];
  endfunction

  function automatic fetch_pkg::offset_t pc_offset(input fetch_pkg::addr_t pc);
    return pc[2 +: fetch_pkg::OFFSET_W];
  endfunction

  fetch_pkg::inst_t               data_q[fetch_pkg::L1I_SETS][fetch_pkg::L1I_WORDS];
  fetch_pkg::tag_t                tag_q[fetch_pkg::L1I_SETS];
  logic [fetch_pkg::L1I_SETS-1:0] valid_q;

  fetch_pkg::l1i_state_e state_q;
  fetch_pkg::fetch_req_t miss_q;        // Request waiting on the refill.
  fetch_pkg::fetch_rsp_t rsp_q;
  logic                  rsp_valid_q;
  logic                  flush_seen_q;  // Line in flight is stale.

  fetch_pkg::index_t  lookup_idx;
  fetch_pkg::offset_t lookup_off;
  fetch_pkg::index_t  fill_idx;
  fetch_pkg::offset_t fill_off;
  logic               lookup_hit;
  logic               accept;
  logic               beat0_write;
  logic               fill_done;

  assign lookup_idx = pc_index(req_i.pc);
  assign lookup_off = pc_offset(req_i.pc);

  // A lookup in the flush cycle already sees the cache empty.
  assign lookup_hit = valid_q[lookup_idx] && (tag_q[lookup_idx] == pc_tag(req_i.pc)) &&
                      !flush_i;

  // One request at a time, the response slot may drain on the same edge.
  assign req_ready_o = (state_q == fetch_pkg::L1I_IDLE) && (!rsp_valid_q || rsp_ready_i);
  assign accept = req_valid_i && req_ready_o;

  assign fill_idx = pc_index(miss_q.pc);
  assign fill_off = pc_offset(miss_q.pc);
  assign beat0_write = (state_q == fetch_pkg::L1I_BEAT0) && mem_rsp_valid_i;
  assign fill_done = (state_q == fetch_pkg::L1I_BEAT1) && mem_rsp_valid_i && mem_rsp_i.last;

  assign mem_req_valid_o = (state_q == fetch_pkg::L1I_REQ);
  assign mem_req_o.addr = {miss_q.pc[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_W+2],
                           {(fetch_pkg::OFFSET_W + 2){1'b0}}};

  assign rsp_o = rsp_q;
  assign rsp_valid_o = rsp_valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= fetch_pkg::L1I_IDLE;
    end else begin
      case (state_q)
        fetch_pkg::L1I_IDLE: begin
          if (accept && !lookup_hit) begin
            state_q <= fetch_pkg::L1I_REQ;
          end
        end
        fetch_pkg::L1I_REQ: begin
          if (mem_req_ready_i) begin
            state_q <= fetch_pkg::L1I_BEAT0;
          end
        end
        fetch_pkg::L1I_BEAT0: begin
          if (mem_rsp_valid_i) begin
            state_q <= fetch_pkg::L1I_BEAT1;
          end
        end
        fetch_pkg::L1I_BEAT1: begin
          if (fill_done) begin
            state_q <= fetch_pkg::L1I_IDLE;
          end
        end
        default: begin
          state_q <= fetch_pkg::L1I_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= lookup_hit;  // Hit answers next cycle.
    end else if (fill_done) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      miss_q <= req_i;
      rsp_q.pc <= req_i.pc;
      rsp_q.inst <= data_q[lookup_idx][lookup_off];
    end else if (fill_done) begin
      rsp_q.pc <= miss_q.pc;
      // Word 1 is still on the bus, word 0 is already in the line.
      rsp_q.inst <= (fill_off == 1'b1) ? mem_rsp_i.data : data_q[fill_idx][0];
    end
  end

  always_ff @(posedge clk) begin
    if (beat0_write) begin
      data_q[fill_idx][0] <= mem_rsp_i.data;
    end
    if (fill_done) begin
      data_q[fill_idx][1] <= mem_rsp_i.data;
      tag_q[fill_idx] <= pc_tag(miss_q.pc);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      flush_seen_q <= 1'b0;
    end else begin
      if (flush_i) begin
        valid_q <= '0;
      end else if (fill_done && !flush_seen_q) begin
        valid_q[fill_idx] <= 1'b1;
      end
      if (fill_done) begin
        flush_seen_q <= 1'b0;
      end else if (flush_i && (state_q != fetch_pkg::L1I_IDLE)) begin
        flush_seen_q <= 1'b1;
      end
    end
  end

  a_beat_expected: assert property (
    @(posedge clk) disable iff (rst)
    mem_rsp_valid_i |-> (state_q == fetch_pkg::L1I_BEAT0 || state_q == fetch_pkg::L1I_BEAT1)
  ) else $error("l1i_cache: bus beat outside a refill");

  a_req_stable: assert property (
    @(posedge clk) disable iff (rst)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o)
  ) else $error("l1i_cache: bus request changed while stalled");

endmodule

//--- design/inst_classify.sv
`timescale 1ns/1ns

module inst_classify (
  input  logic                  clk,
  input  logic                  rst,
  input  fetch_pkg::fetch_rsp_t in_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  output fetch_pkg::fetch_out_t fetch_o,
  output logic                  fetch_valid_o,
  input  logic                  fetch_ready_i,
  output logic                  halt_o,
  output logic                  flush_cache_o,
  input  logic                  redirect_valid_i
);

  function automatic fetch_pkg::inst_kind_e classify(input fetch_pkg::inst_t inst);
    fetch_pkg::inst_kind_e kind;
    kind = fetch_pkg::KIND_SEQ;
    case (inst[6:0])
      fetch_pkg::OP_JAL,
      fetch_pkg::OP_JALR,
      fetch_pkg::OP_BRANCH,
      fetch_pkg::OP_SYSTEM: begin
        kind = fetch_pkg::KIND_CTRL;
      end
      fetch_pkg::OP_MISC_MEM: begin
        if (inst[14:12] == fetch_pkg::INST_FENCE_I[14:12]) begin
          kind = fetch_pkg::KIND_FENCE_I;  // Plain FENCE stays sequential.
        end
      end
      default: begin
        kind = fetch_pkg::KIND_SEQ;
      end
    endcase
    return kind;
  endfunction

  fetch_pkg::fetch_out_t out_q;
  logic                  out_valid_q;
  logic                  halt_q;
  fetch_pkg::inst_kind_e in_kind;
  logic                  take;
  logic                  keep;

  assign in_kind = classify(in_i.inst);

  // Halted, every item is taken and dropped.
  assign in_ready_o = halt_q || !out_valid_q || fetch_ready_i;
  assign take = in_valid_i && in_ready_o;
  assign keep = take && !halt_q;

  // The taken jump stops pc_gen on the same edge.
  assign halt_o = halt_q || (keep && (in_kind == fetch_pkg::KIND_CTRL));

  assign fetch_o = out_q;
  assign fetch_valid_o = out_valid_q;
  assign flush_cache_o = out_valid_q && fetch_ready_i && (out_q.kind == fetch_pkg::KIND_FENCE_I);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_q <= 1'b0;
    end else if (keep) begin
      out_valid_q <= 1'b1;
    end else if (fetch_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (keep) begin
      out_q.pc <= in_i.pc;
      out_q.inst <= in_i.inst;
      out_q.kind <= in_kind;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      halt_q <= 1'b0;
    end else if (keep && (in_kind == fetch_pkg::KIND_CTRL)) begin
      halt_q <= 1'b1;
    end else if (redirect_valid_i) begin
      halt_q <= 1'b0;
    end
  end

endmodule

//--- design/fetch_top.sv
`timescale 1ns/1ns

module fetch_top (
  input  logic                  clk,
  input  logic                  rst,
  output fetch_pkg::mem_req_t   mem_req_o,
  output logic                  mem_req_valid_o,
  input  logic                  mem_req_ready_i,
  input  fetch_pkg::mem_rsp_t   mem_rsp_i,
  input  logic                  mem_rsp_valid_i,
  output fetch_pkg::fetch_out_t fetch_o,
  output logic                  fetch_valid_o,
  input  logic                  fetch_ready_i,
  input  logic                  redirect_valid_i,
  input  fetch_pkg::addr_t      redirect_pc_i
);

  fetch_pkg::fetch_req_t req;
  logic                  req_valid;
  logic                  req_ready;
  fetch_pkg::fetch_rsp_t rsp;
  logic                  rsp_valid;
  logic                  rsp_ready;
  logic                  halt;
  logic                  flush_cache;

  pc_gen i_pc_gen (
    .clk              (clk),
    .rst              (rst),
    .req_o            (req),
    .req_valid_o      (req_valid),
    .req_ready_i      (req_ready),
    .halt_i           (halt),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i)
  );

  l1i_cache i_l1i_cache (
    .clk             (clk),
    .rst             (rst),
    .req_i           (req),
    .req_valid_i     (req_valid),
    .req_ready_o     (req_ready),
    .rsp_o           (rsp),
    .rsp_valid_o     (rsp_valid),
    .rsp_ready_i     (rsp_ready),
    .flush_i         (flush_cache),
    .mem_req_o       (mem_req_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_i       (mem_rsp_i),
    .mem_rsp_valid_i (mem_rsp_valid_i)
  );

  inst_classify i_inst_classify (
    .clk              (clk),
    .rst              (rst),
    .in_i             (rsp),
    .in_valid_i       (rsp_valid),
    .in_ready_o       (rsp_ready),
    .fetch_o          (fetch_o),
    .fetch_valid_o    (fetch_valid_o),
    .fetch_ready_i    (fetch_ready_i),
    .halt_o           (halt),
    .flush_cache_o    (flush_cache),
    .redirect_valid_i (redirect_valid_i)
  );

endmodule

//--- tests/fetch_checker.sv
`timescale 1ns/1ns

module fetch_checker (
  input  logic                  clk,
  input  logic                  rst,
  input  fetch_pkg::fetch_out_t fetch_i,
  input  logic                  fetch_valid_i,
  input  logic                  fetch_ready_i,
  input  fetch_pkg::mem_req_t   mem_req_i,
  input  logic                  mem_req_valid_i,
  input  logic                  mem_req_ready_i,
  input  fetch_pkg::mem_rsp_t   mem_rsp_i,
  input  logic                  mem_rsp_valid_i,
  input  logic                  redirect_valid_i,
  input  fetch_pkg::addr_t      redirect_pc_i,
  output int                    out_count_o,
  output int                    value_errors_o,
  output int                    other_errors_o
);

  // Program image: sequential words, control flow at a few addresses, one FENCE.I.
  function automatic fetch_pkg::inst_t mem_word(input fetch_pkg::addr_t addr);
    fetch_pkg::inst_t word;
    word = {addr[31:20] ^ addr[13:2], 5'd0, 3'b000, 5'd1, 7'b0010011};
    case (addr)
      32'h8000_001c: word = 32'h0000_006f;  // JAL.
      32'h8000_0048: word = 32'h0000_100f;  // FENCE.I.
      32'h8000_0050: word = 32'h0000_0063;  // BEQ.
      default: word = word;
    endcase
    return word;
  endfunction

  function automatic fetch_pkg::inst_kind_e ref_kind(input fetch_pkg::inst_t inst);
    if (inst[6:0] == 7'b1101111 || inst[6:0] == 7'b1100111 ||
        inst[6:0] == 7'b1100011 || inst[6:0] == 7'b1110011) begin
      return fetch_pkg::KIND_CTRL;
    end
    if (inst[6:0] == 7'b0001111 && inst[14:12] == 3'b001) begin
      return fetch_pkg::KIND_FENCE_I;
    end
    return fetch_pkg::KIND_SEQ;
  endfunction

  // Sequential step, control flow waits for the redirect.
  function automatic fetch_pkg::addr_t next_pc(input fetch_pkg::addr_t pc);
    return pc + 32'd4;
  endfunction

  fetch_pkg::addr_t      exp_pc;
  fetch_pkg::addr_t      ahead_pc;
  fetch_pkg::inst_t      exp_inst;
  fetch_pkg::inst_kind_e exp_kind;
  logic                  halted;
  logic                  hold_q;
  fetch_pkg::fetch_out_t held_q;
  logic [3:0]            line_valid;
  logic [26:0]           line_tag[4];
  logic [3:0]            stale_valid;  // Lines that were cached when FENCE.I left.
  logic [26:0]           stale_tag[4];
  logic                  fence_shadow;  // Next output was looked up before the flush.
  logic                  in_flight;
  logic                  fill_stale;
  logic [1:0]            fill_set;
  logic [26:0]           fill_tag;
  int                    count;
  int                    value_errors;
  int                    other_errors;

  assign out_count_o = count;
  assign value_errors_o = value_errors;
  assign other_errors_o = other_errors;

  always @(posedge clk) begin
    if (rst) begin
      exp_pc = fetch_pkg::PC_RESET;
      halted = 1'b0;
      hold_q = 1'b0;
      line_valid = '0;
      stale_valid = '0;
      fence_shadow = 1'b0;
      in_flight = 1'b0;
      fill_stale = 1'b0;
      count = 0;
      value_errors = 0;
      other_errors = 0;
    end else begin
      if (hold_q) begin
        if (!fetch_valid_i) begin
          other_errors++;
          $display("Time %0t: fetch_valid_o dropped while the output was stalled", $time);
        end else if (fetch_i != held_q) begin
          value_errors++;
          $display("FAILED %0t fetch_o: expected %h got %h", $time, held_q, fetch_i);
        end
      end
      hold_q = fetch_valid_i && !fetch_ready_i;
      held_q = fetch_i;

      if (fetch_valid_i && fetch_ready_i) begin
        exp_inst = mem_word(exp_pc);
        exp_kind = ref_kind(exp_inst);
        if (halted) begin
          other_errors++;
          $display("Time %0t: output appeared before the redirect", $time);
        end
        if (fetch_i.pc != exp_pc) begin
          value_errors++;
          $display("FAILED %0t fetch_o.pc: expected %h got %h", $time, exp_pc, fetch_i.pc);
        end
        if (fetch_i.inst != exp_inst) begin
          value_errors++;
          $display("FAILED %0t fetch_o.inst: expected %h got %h", $time, exp_inst,
                   fetch_i.inst);
        end
        if (fetch_i.kind != exp_kind) begin
          value_errors++;
          $display("FAILED %0t fetch_o.kind: expected %0d got %0d", $time, exp_kind,
                   fetch_i.kind);
        end
        if (!fence_shadow && stale_valid[exp_pc[4:3]] &&
            stale_tag[exp_pc[4:3]] == exp_pc[31:5]) begin
          other_errors++;
          $display("Time %0t: line of %h served after FENCE.I without a refill", $time,
                   exp_pc);
        end
        fence_shadow = 1'b0;
        count++;
        exp_pc = next_pc(exp_pc);
        if (exp_kind == fetch_pkg::KIND_CTRL) begin
          halted = 1'b1;
        end
        if (exp_kind == fetch_pkg::KIND_FENCE_I) begin
          stale_valid = line_valid;
          stale_tag = line_tag;
          line_valid = '0;
          fence_shadow = 1'b1;
          if (in_flight || mem_req_valid_i) begin
            fill_stale = 1'b1;
          end
        end
      end

      if (redirect_valid_i) begin
        if (!halted) begin
          other_errors++;
          $display("Time %0t: redirect arrived while fetch was running", $time);
        end
        halted = 1'b0;
        exp_pc = redirect_pc_i;
      end

      if (mem_req_valid_i && mem_req_ready_i) begin
        if (mem_req_i.addr[2:0] != 3'b000) begin
          value_errors++;
          $display("FAILED %0t mem_req_o.addr: expected %h got %h", $time,
                   {mem_req_i.addr[31:3], 3'b000}, mem_req_i.addr);
        end
        ahead_pc = next_pc(exp_pc);  // The output register may still hold exp_pc.
        if (mem_req_i.addr[31:3] != exp_pc[31:3] &&
            mem_req_i.addr[31:3] != ahead_pc[31:3]) begin
          other_errors++;
          $display("Time %0t: bus refill for line %h that fetch does not need next", $time,
                   mem_req_i.addr);
        end
        fill_set = mem_req_i.addr[4:3];
        fill_tag = mem_req_i.addr[31:5];
        if (line_valid[fill_set] && line_tag[fill_set] == fill_tag) begin
          report_cached_refill();
        end
        if (stale_valid[fill_set] && stale_tag[fill_set] == fill_tag) begin
          stale_valid[fill_set] = 1'b0;
        end
        in_flight = 1'b1;
      end

      if (mem_rsp_valid_i && mem_rsp_i.last) begin
        if (!fill_stale) begin
          line_valid[fill_set] = 1'b1;
          line_tag[fill_set] = fill_tag;
        end
        fill_stale = 1'b0;
        in_flight = 1'b0;
      end
    end
  end

  task automatic report_cached_refill();
    other_errors++;
    $display("Time %0t: bus refill for line %h that is already cached", $time,
             {fill_tag, fill_set, 3'b000});
  endtask

endmodule

//--- tests/tb_fetch_top.sv
`timescale 1ns/1ns

module tb_fetch_top;

  localparam int N_EXPECTED = 31;  // 8 + 4 + 5 + 8 + 6 outputs.
  localparam int N_REDIRECT = 4;
  localparam int TIMEOUT_NS = (8 + 40 * N_EXPECTED) * 40;

  localparam fetch_pkg::addr_t TARGETS[N_REDIRECT] = '{
    32'h8000_0010,  // Hits the lines fetched first.
    32'h8000_0040,  // Runs into the FENCE.I.
    32'h8000_0000,  // Refills after the flush.
    32'h8000_0008
  };

  logic                  clk;
  logic                  rst;
  fetch_pkg::mem_req_t   mem_req_o;
  logic                  mem_req_valid_o;
  logic                  mem_req_ready_i;
  fetch_pkg::mem_rsp_t   mem_rsp_i;
  logic                  mem_rsp_valid_i;
  fetch_pkg::fetch_out_t fetch_o;
  logic                  fetch_valid_o;
  logic                  fetch_ready_i;
  logic                  redirect_valid_i;
  fetch_pkg::addr_t      redirect_pc_i;

  int               out_count;
  int               value_errors;
  int               other_errors;
  int               redirect_count;
  int               wait_cycles;
  int               latency;
  fetch_pkg::addr_t line_addr;

  fetch_top i_fetch_top (
    .clk              (clk),
    .rst              (rst),
    .mem_req_o        (mem_req_o),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_rsp_i        (mem_rsp_i),
    .mem_rsp_valid_i  (mem_rsp_valid_i),
    .fetch_o          (fetch_o),
    .fetch_valid_o    (fetch_valid_o),
    .fetch_ready_i    (fetch_ready_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i)
  );

  fetch_checker i_fetch_checker (
    .clk              (clk),
    .rst              (rst),
    .fetch_i          (fetch_o),
    .fetch_valid_i    (fetch_valid_o),
    .fetch_ready_i    (fetch_ready_i),
    .mem_req_i        (mem_req_o),
    .mem_req_valid_i  (mem_req_valid_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_rsp_i        (mem_rsp_i),
    .mem_rsp_valid_i  (mem_rsp_valid_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .out_count_o      (out_count),
    .value_errors_o   (value_errors),
    .other_errors_o   (other_errors)
  );

  always #20 clk = ~clk;

  initial begin
    void'($urandom(97));
    clk = 1'b0;
    rst = 1'b1;
    mem_req_ready_i = 1'b0;
    mem_rsp_i = '0;
    mem_rsp_valid_i = 1'b0;
    fetch_ready_i = 1'b0;
    redirect_valid_i = 1'b0;
    redirect_pc_i = '0;
    redirect_count = 0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    wait (out_count == N_EXPECTED);
    repeat (20) @(posedge clk);  // Catch any extra output.
    $display("Outputs %0d of %0d, value errors %0d, other errors %0d", out_count,
             N_EXPECTED, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0 && out_count == N_EXPECTED) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Random back-pressure on the output and the bus.
  always @(posedge clk) begin
    fetch_ready_i <= ($urandom % 10) >= 3;
    mem_req_ready_i <= ($urandom % 2) == 0;
  end

  // Memory responder, two beats after 1 to 6 cycles.
  initial begin
    forever begin
      @(posedge clk);
      if (!rst && mem_req_valid_o && mem_req_ready_i) begin
        line_addr = mem_req_o.addr;
        latency = 1 + $urandom % 6;
        repeat (latency - 1) @(posedge clk);
        mem_rsp_valid_i <= 1'b1;
        mem_rsp_i <= {i_fetch_checker.mem_word(line_addr), 1'b0};
        @(posedge clk);
        mem_rsp_i <= {i_fetch_checker.mem_word(line_addr + 32'd4), 1'b1};
        @(posedge clk);
        mem_rsp_valid_i <= 1'b0;
      end
    end
  end

  // Execute side, redirects after each control-flow output.
  initial begin
    forever begin
      @(posedge clk);
      if (!rst && fetch_valid_o && fetch_ready_i && fetch_o.kind == fetch_pkg::KIND_CTRL &&
          redirect_count < N_REDIRECT) begin
        wait_cycles = $urandom % 6;
        repeat (wait_cycles) @(posedge clk);
        redirect_valid_i <= 1'b1;
        redirect_pc_i <= TARGETS[redirect_count];
        redirect_count++;
        @(posedge clk);
        redirect_valid_i <= 1'b0;
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: only %0d of %0d outputs seen, value errors %0d, other errors %0d",
             out_count, N_EXPECTED, value_errors, other_errors);
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- sources.f
design/fetch_pkg.sv
design/pc_gen.sv
design/l1i_cache.sv
design/inst_classify.sv
design/fetch_top.sv
tests/fetch_checker.sv
tests/tb_fetch_top.sv
